//--- design/irq_pkg.sv
// irq package with the shared widths, privilege levels, register map and config word views

package irq_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // number of level-sensitive interrupt lines
  localparam int NUM_IRQ  = 32;

  // width of an interrupt id, enough to name every line
  localparam int IRQ_ID_W = 5;

  // interrupt id, index of a line
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  //////////////////////////////
  // privilege
  //////////////////////////////

  // current privilege level of the core
  // only user and machine mode take part in the enable decision
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  //////////////////////////////
  // configuration map
  //////////////////////////////

  // register addresses on the shared write bus
  // mask and secure mask live in the arbiter, status in the enable unit
  typedef enum logic [1:0] {
    CFG_MASK    = 2'b00,
    CFG_SECMASK = 2'b01,
    CFG_STATUS  = 2'b10
  } cfg_addr_t;

  // status word, privilege level in the two lsbs
  typedef struct packed {
    logic [27:0] reserved;
    logic        mie;
    logic        uie;
    priv_lvl_t   prv;
  } irq_status_t;

  // one write word, seen as a line mask by the arbiter
  // and as a status word by the enable unit
  typedef union packed {
    logic [NUM_IRQ-1:0] lines;
    irq_status_t        status;
  } cfg_word_u;

endpackage

//--- design/irq_line_arbiter.sv
// line arbiter, masks the interrupt lines and registers the lowest pending line with its secure bit

`timescale 1ns/1ps

module irq_line_arbiter
(
  input  logic                          clk,
  input  logic                          rst_n,

  // level-sensitive interrupt lines
  input  logic [irq_pkg::NUM_IRQ-1:0]   irq_lines_i,

  // configuration write bus
  input  logic                          cfg_we_i,
  input  irq_pkg::cfg_addr_t            cfg_addr_i,
  input  irq_pkg::cfg_word_u            cfg_wdata_i,

  // winner towards the interrupt controller
  output logic                          arb_valid_o,
  output irq_pkg::irq_id_t              arb_id_o,
  output logic                          arb_sec_o
);

  import irq_pkg::*;

  // per-line enable and per-line secure attribute
  logic [NUM_IRQ-1:0] mask_q;
  logic [NUM_IRQ-1:0] secmask_q;

  // lines that survive the mask
  logic [NUM_IRQ-1:0] masked;

  // combinational winner before the output register
  logic               win_any;
  irq_id_t            win_id;
  logic               win_sec;

  //////////////////////////////
  // configuration registers
  //////////////////////////////

  // only the two line addresses belong here, status is ignored
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mask_q    <= '0;
      secmask_q <= '0;
    end
    else if (cfg_we_i)
    begin
      if (cfg_addr_i == CFG_MASK)
      begin
        mask_q <= cfg_wdata_i.lines;
      end
      if (cfg_addr_i == CFG_SECMASK)
      begin
        secmask_q <= cfg_wdata_i.lines;
      end
    end
  end

  //////////////////////////////
  // priority select
  //////////////////////////////

  assign masked  = irq_lines_i & mask_q;
  assign win_any = |masked;

  // scan from the top down so the lowest set index is written last
  // index 0 has the highest priority
  always_comb
  begin
    win_id = '0;
    for (int i = NUM_IRQ - 1; i >= 0; i--)
    begin
      if (masked[i])
      begin
        win_id = irq_id_t'(i);
      end
    end
  end

  // secure attribute of the winning line
  assign win_sec = secmask_q[win_id] & win_any;

  //////////////////////////////
  // output register
  //////////////////////////////

  // one cycle from line to arb_valid_o
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      arb_valid_o <= 1'b0;
      arb_id_o    <= '0;
      arb_sec_o   <= 1'b0;
    end
    else
    begin
      arb_valid_o <= win_any;
      arb_id_o    <= win_id;
      arb_sec_o   <= win_sec;
    end
  end

endmodule

//--- design/irq_enable_unit.sv
// enable unit, holds the status word and decides whether external interrupts are taken

`timescale 1ns/1ps

module irq_enable_unit
#(
  // 1 uses the secure scheme, 0 looks at mie only
  parameter bit SECURE = 1'b1
)
(
  input  logic                clk,
  input  logic                rst_n,

  // configuration write bus
  input  logic                cfg_we_i,
  input  irq_pkg::cfg_addr_t  cfg_addr_i,
  input  irq_pkg::cfg_word_u  cfg_wdata_i,

  // secure bit of the current winner, used as qualifier only
  input  logic                arb_sec_i,

  // external interrupt enable towards the controller
  output logic                irq_enable_o
);

  import irq_pkg::*;

  // status word, cleared to user mode with both enables off
  irq_status_t status_q;

  //////////////////////////////
  // status register
  //////////////////////////////

  // mask addresses belong to the arbiter and are ignored here
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      status_q <= '0;
    end
    else if (cfg_we_i && (cfg_addr_i == CFG_STATUS))
    begin
      status_q <= cfg_wdata_i.status;
    end
  end

  //////////////////////////////
  // enable decision
  //////////////////////////////

  generate
    if (SECURE)
    begin : g_secure
      // user mode, taken with uie or when the line is secure
      logic en_user;
      // machine mode, taken with mie
      logic en_mach;

      assign en_user = (status_q.prv == PRIV_LVL_U) && (status_q.uie || arb_sec_i);
      assign en_mach = (status_q.prv == PRIV_LVL_M) && status_q.mie;

      assign irq_enable_o = en_user | en_mach;
    end
    else
    begin : g_plain
      // no privilege split, mie alone decides
      assign irq_enable_o = status_q.mie;
    end
  endgenerate

endmodule

//--- design/irq_int_controller.sv
// interrupt controller, latches the arbiter winner and holds the request until the core acks or kills it

`timescale 1ns/1ps

module irq_int_controller
(
  input  logic              clk,
  input  logic              rst_n,

  // winner from the line arbiter
  input  logic              arb_valid_i,
  input  irq_pkg::irq_id_t  arb_id_i,
  input  logic              arb_sec_i,

  // external interrupt enable from the enable unit
  input  logic              irq_enable_i,

  // pulses from the core's controller
  input  logic              ctrl_ack_i,
  input  logic              ctrl_kill_i,

  // request towards the core
  output logic              irq_req_o,
  output logic              irq_sec_o,
  output irq_pkg::irq_id_t  irq_id_o
);

  import irq_pkg::*;

  // request sequencer states
  typedef enum logic [1:0] {
    IDLE        = 2'b00,
    IRQ_PENDING = 2'b01,
    IRQ_DONE    = 2'b10
  } ctrl_state_t;

  ctrl_state_t state_q;

  // latched winner, held for the whole request
  irq_id_t     irq_id_q;
  logic        irq_sec_q;

  //////////////////////////////
  // sequencer
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= IDLE;
      irq_id_q  <= '0;
      irq_sec_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          // take the winner only while enabled
          if (irq_enable_i && arb_valid_i)
          begin
            state_q   <= IRQ_PENDING;
            irq_id_q  <= arb_id_i;
            irq_sec_q <= arb_sec_i;
          end
        end

        IRQ_PENDING:
        begin
          // ack wins over kill when both arrive
          if (ctrl_ack_i)
          begin
            state_q <= IRQ_DONE;
          end
          else if (ctrl_kill_i)
          begin
            state_q <= IDLE;
          end
        end

        IRQ_DONE:
        begin
          // handler entered, drop the secure flag
          irq_sec_q <= 1'b0;
          state_q   <= IDLE;
        end

        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  // the request is a plain level, high only while pending
  assign irq_req_o = (state_q == IRQ_PENDING);
  assign irq_sec_o = irq_sec_q;
  assign irq_id_o  = irq_id_q;

endmodule

//--- design/irq_subsystem.sv
// interrupt subsystem top, arbiter and enable unit side by side feeding the request controller

`timescale 1ns/1ps

module irq_subsystem
#(
  // secure scheme on the enable decision
  parameter bit SECURE = 1'b1
)
(
  input  logic                         clk,
  input  logic                         rst_n,

  // interrupt lines from the peripherals
  input  logic [irq_pkg::NUM_IRQ-1:0]  irq_lines_i,

  // configuration write bus, shared by arbiter and enable unit
  input  logic                         cfg_we_i,
  input  irq_pkg::cfg_addr_t           cfg_addr_i,
  input  irq_pkg::cfg_word_u           cfg_wdata_i,

  // core side
  input  logic                         ctrl_ack_i,
  input  logic                         ctrl_kill_i,
  output logic                         irq_req_o,
  output irq_pkg::irq_id_t             irq_id_o,
  output logic                         irq_sec_o
);

  import irq_pkg::*;

  // arbiter winner
  logic    arb_valid;
  irq_id_t arb_id;
  logic    arb_sec;

  // enable decision
  logic    irq_enable;

  //////////////////////////////
  // line arbiter
  //////////////////////////////

  // each block decodes only its own addresses
  irq_line_arbiter u_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_lines_i (irq_lines_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .arb_valid_o (arb_valid),
    .arb_id_o    (arb_id),
    .arb_sec_o   (arb_sec)
  );

  //////////////////////////////
  // enable unit
  //////////////////////////////

  irq_enable_unit #(
    .SECURE (SECURE)
  ) u_enable (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .arb_sec_i    (arb_sec),
    .irq_enable_o (irq_enable)
  );

  //////////////////////////////
  // request controller
  //////////////////////////////

  irq_int_controller u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .arb_valid_i  (arb_valid),
    .arb_id_i     (arb_id),
    .arb_sec_i    (arb_sec),
    .irq_enable_i (irq_enable),
    .ctrl_ack_i   (ctrl_ack_i),
    .ctrl_kill_i  (ctrl_kill_i),
    .irq_req_o    (irq_req_o),
    .irq_sec_o    (irq_sec_o),
    .irq_id_o     (irq_id_o)
  );

endmodule

//--- tests/irq_assertions.sv
// request protocol checks, bound into the interrupt controller

`timescale 1ns/1ps

module irq_assertions
(
  input logic             clk,
  input logic             rst_n,
  input logic             ctrl_ack_i,
  input logic             ctrl_kill_i,
  input logic             irq_req_o,
  input irq_pkg::irq_id_t irq_id_o
);

  // failures so far, summed up by the testbench
  int fail_cnt = 0;

  // nothing comes straight out of reset
  req_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !irq_req_o)
  else
  begin
    $error("request high in the cycle after reset release");
    fail_cnt++;
  end

  // latched id stays put until the core answers
  id_stable_while_pending: assert property (@(posedge clk) disable iff (!rst_n)
    (irq_req_o && !ctrl_ack_i && !ctrl_kill_i) |=> $stable(irq_id_o))
  else
  begin
    $error("irq id changed while the request was held");
    fail_cnt++;
  end

  // ack ends the request on the next edge
  req_low_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    (irq_req_o && ctrl_ack_i) |=> !irq_req_o)
  else
  begin
    $error("request still high in the cycle after ack");
    fail_cnt++;
  end

endmodule

bind irq_int_controller irq_assertions u_irq_assertions (
  .clk         (clk),
  .rst_n       (rst_n),
  .ctrl_ack_i  (ctrl_ack_i),
  .ctrl_kill_i (ctrl_kill_i),
  .irq_req_o   (irq_req_o),
  .irq_id_o    (irq_id_o)
);

//--- tests/irq_tb.sv
// directed testbench for the interrupt subsystem, plays the core through ack and kill

`timescale 1ns/1ps

module irq_tb;

  import irq_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_TRIALS  = 12;
  // six tests, the random one is the longest
  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 300;
  localparam int TIMEOUT_NS  = 2 * NUM_TESTS * TEST_CYCLES * CLK_PERIOD;

  logic               clk;
  logic               rst_n;
  logic [NUM_IRQ-1:0] irq_lines;
  logic               cfg_we;
  cfg_addr_t          cfg_addr;
  cfg_word_u          cfg_wdata;
  logic               ctrl_ack;
  logic               ctrl_kill;
  logic               irq_req;
  irq_id_t            irq_id;
  logic               irq_sec;

  int err_cnt   = 0;
  int check_cnt = 0;

  irq_subsystem #(.SECURE(1'b1)) u_irq_subsystem (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_lines_i (irq_lines),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .ctrl_ack_i  (ctrl_ack),
    .ctrl_kill_i (ctrl_kill),
    .irq_req_o   (irq_req),
    .irq_id_o    (irq_id),
    .irq_sec_o   (irq_sec)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // stops a run that hangs on a missing request
  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  // outputs are sampled on the falling edge, half a cycle after they change
  task automatic check_req(input logic exp, input string what);
    check_cnt++;
    if (irq_req !== exp)
    begin
      err_cnt++;
      $display("FAILED at %0t: irq_req_o %b, expected %b, %s", $time, irq_req, exp, what);
    end
  endtask

  task automatic check_id(input irq_id_t exp, input string what);
    check_cnt++;
    if (irq_id !== exp)
    begin
      err_cnt++;
      $display("FAILED at %0t: irq_id_o %0d, expected %0d, %s", $time, irq_id, exp, what);
    end
  endtask

  task automatic check_sec(input logic exp, input string what);
    check_cnt++;
    if (irq_sec !== exp)
    begin
      err_cnt++;
      $display("FAILED at %0t: irq_sec_o %b, expected %b, %s", $time, irq_sec, exp, what);
    end
  endtask

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // status view of a config word
  function automatic cfg_word_u make_status(input logic mie, input logic uie,
                                            input priv_lvl_t prv);
    cfg_word_u w;
    w            = '0;
    w.status.mie = mie;
    w.status.uie = uie;
    w.status.prv = prv;
    return w;
  endfunction

  // index 0 wins, searched upward
  function automatic irq_id_t lowest_set(input logic [NUM_IRQ-1:0] v);
    irq_id_t id;
    bit      found;
    id    = '0;
    found = 1'b0;
    for (int i = 0; i < NUM_IRQ; i++)
    begin
      if (v[i] && !found)
      begin
        id    = irq_id_t'(i);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  // one-cycle strobe, the register takes it on the second edge
  task automatic write_cfg(input cfg_addr_t addr, input cfg_word_u word);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= word;
    @(posedge clk);
    cfg_we    <= 1'b0;
  endtask

  task automatic expect_quiet(input int cycles, input string what);
    repeat (cycles)
    begin
      @(negedge clk);
      check_req(1'b0, what);
    end
  endtask

  // bounded wait for the request level
  task automatic wait_for_req(input int max_cycles, input string what);
    int  n;
    bit  seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < max_cycles)
    begin
      @(negedge clk);
      n++;
      seen = irq_req;
    end
    if (!seen)
    begin
      err_cnt++;
      $display("no request appeared within %0d cycles, %s", max_cycles, what);
    end
  endtask

  // core takes the interrupt, the source drops its line at the same time
  task automatic ack_and_release();
    @(posedge clk);
    irq_lines <= '0;
    ctrl_ack  <= 1'b1;
    @(posedge clk);
    ctrl_ack  <= 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (err_cnt == errs_at_start)
      $display("%s: ok", name);
    else
      $display("%s: %0d mismatches", name, err_cnt - errs_at_start);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  // masks and enables are clear after reset, so nothing gets through
  task automatic reset_values();
    int errs;
    errs = err_cnt;
    @(posedge clk);
    irq_lines <= '1;
    expect_quiet(4, "all lines high after reset");
    check_id('0, "id after reset");
    check_sec(1'b0, "secure flag after reset");
    @(posedge clk);
    irq_lines <= '0;
    report_test("reset values", errs);
  endtask

  task automatic priority_and_ack();
    int errs;
    errs = err_cnt;
    write_cfg(CFG_MASK, '1);
    write_cfg(CFG_STATUS, make_status(1'b1, 1'b0, PRIV_LVL_M));
    @(posedge clk);
    irq_lines <= (32'd1 << 7) | (32'd1 << 3);
    // arbiter register, then controller register
    expect_quiet(2, "request before the two cycle latency");
    @(negedge clk);
    check_req(1'b1, "request two cycles after lines 7 and 3");
    check_id(irq_id_t'(3), "lowest line wins");
    // a late higher priority line leaves the latched id alone
    @(posedge clk);
    irq_lines <= (32'd1 << 7) | (32'd1 << 3) | (32'd1 << 1);
    @(negedge clk);
    @(negedge clk);
    check_id(irq_id_t'(3), "id held while pending");
    ack_and_release();
    expect_quiet(4, "request after ack with lines dropped");
    report_test("priority and ack", errs);
  endtask

  task automatic mask_and_enable();
    int errs;
    errs = err_cnt;
    write_cfg(CFG_MASK, ~(32'd1 << 4));
    @(posedge clk);
    irq_lines <= 32'd1 << 4;
    expect_quiet(5, "masked line 4");
    @(posedge clk);
    irq_lines <= '0;
    write_cfg(CFG_STATUS, make_status(1'b0, 1'b0, PRIV_LVL_M));
    @(posedge clk);
    irq_lines <= 32'd1 << 9;
    expect_quiet(5, "line 9 with mie clear");
    write_cfg(CFG_STATUS, make_status(1'b1, 1'b0, PRIV_LVL_M));
    wait_for_req(2, "line 9 after mie set");
    check_id(irq_id_t'(9), "line 9 after mie set");
    ack_and_release();
    repeat (3) @(posedge clk);
    report_test("mask and enable", errs);
  endtask

  // kill sends the controller back to idle, the line is still up
  task automatic kill_and_retry();
    int errs;
    errs = err_cnt;
    @(posedge clk);
    irq_lines <= 32'd1 << 12;
    wait_for_req(3, "line 12");
    check_id(irq_id_t'(12), "line 12 before kill");
    @(posedge clk);
    ctrl_kill <= 1'b1;
    @(posedge clk);
    ctrl_kill <= 1'b0;
    @(negedge clk);
    check_req(1'b0, "request after kill");
    @(negedge clk);
    check_req(1'b1, "request again one cycle after kill");
    check_id(irq_id_t'(12), "same id after kill");
    ack_and_release();
    repeat (3) @(posedge clk);
    report_test("kill and retry", errs);
  endtask

  task automatic secure_lines();
    int errs;
    errs = err_cnt;
    // user mode, uie off, only secure lines pass
    write_cfg(CFG_STATUS, make_status(1'b0, 1'b0, PRIV_LVL_U));
    write_cfg(CFG_SECMASK, 32'd1 << 5);
    @(posedge clk);
    irq_lines <= 32'd1 << 5;
    wait_for_req(3, "secure line 5 in user mode");
    check_id(irq_id_t'(5), "secure line 5");
    check_sec(1'b1, "secure flag for line 5");
    ack_and_release();
    @(negedge clk);
    check_sec(1'b1, "secure flag one cycle after ack");
    @(negedge clk);
    check_sec(1'b0, "secure flag two cycles after ack");
    @(posedge clk);
    irq_lines <= 32'd1 << 2;
    expect_quiet(5, "plain line 2 in user mode with uie clear");
    @(posedge clk);
    irq_lines <= '0;
    report_test("secure lines", errs);
  endtask

  task automatic random_lines();
    int                 errs;
    logic [NUM_IRQ-1:0] mask;
    logic [NUM_IRQ-1:0] lines;
    errs = err_cnt;
    write_cfg(CFG_STATUS, make_status(1'b1, 1'b0, PRIV_LVL_M));
    for (int t = 0; t < NUM_TRIALS; t++)
    begin
      // sparse patterns so the winner moves around
      mask  = $urandom;
      lines = $urandom & $urandom & $urandom;
      if (t == 0)
        mask = '0;
      write_cfg(CFG_MASK, mask);
      @(posedge clk);
      irq_lines <= lines;
      if ((lines & mask) == '0)
      begin
        expect_quiet(4, "random lines fully masked");
        @(posedge clk);
        irq_lines <= '0;
      end
      else
      begin
        wait_for_req(3, "random lines");
        check_id(lowest_set(lines & mask), "random winner");
        ack_and_release();
      end
      repeat (3) @(posedge clk);
    end
    report_test("random lines", errs);
  endtask

  initial
  begin
    void'($urandom(32'hcbd27d19));
    clk       = 1'b0;
    rst_n     = 1'b0;
    irq_lines = '0;
    cfg_we    = 1'b0;
    cfg_addr  = CFG_MASK;
    cfg_wdata = '0;
    ctrl_ack  = 1'b0;
    ctrl_kill = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    reset_values();
    priority_and_ack();
    mask_and_enable();
    kill_and_retry();
    secure_lines();
    random_lines();
    $display("%0d checks, %0d mismatches, %0d assertion failures", check_cnt, err_cnt,
             u_irq_subsystem.u_ctrl.u_irq_assertions.fail_cnt);
    if (err_cnt == 0 && u_irq_subsystem.u_ctrl.u_irq_assertions.fail_cnt == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- tb.f
design/irq_pkg.sv
design/irq_line_arbiter.sv
design/irq_enable_unit.sv
design/irq_int_controller.sv
design/irq_subsystem.sv
tests/irq_assertions.sv
tests/irq_tb.sv

//--- Makefile
# Verilator build and run of the interrupt subsystem testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails on a failing run"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module irq_tb -f tb.f -o irq_sim
	./obj_dir/irq_sim +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
